// ==== source/bootPkg.sv ====
package bootPkg;

    localparam int wordWidth = 16;
    localparam int addrWidth = 10;
    localparam int memDepth  = 1 << addrWidth; // Words per RAM

    // Bit positions inside the 4-bit software reset vector
    localparam int vecFull = 3;
    localparam int vecInst = 2;
    localparam int vecIo   = 1;
    localparam int vecData = 0;

    typedef enum logic [1:0] {idle, flashInst, flashData, submitReset} resetState;

    // Decoded reset request, listed from highest to lowest priority
    typedef enum logic [1:0] {kindFull, kindInst, kindIo, kindData} resetKind;

    localparam logic [wordWidth-1:0] instBase   = 16'h1000;
    localparam logic [wordWidth-1:0] instStride = 16'd3;

    function automatic logic [wordWidth-1:0] instImage(input logic [addrWidth-1:0] a);
        logic [wordWidth-1:0] ext;
        ext = wordWidth'(a);
        return ext * instStride + instBase; // Wraps modulo 2^16
    endfunction

    function automatic logic [wordWidth-1:0] dataImage(input logic [addrWidth-1:0] a);
        return ~wordWidth'(a);
    endfunction

endpackage

// ==== source/bootRom.sv ====
`timescale 1ns/1ns

// Boot image source for both RAMs
// region low gives instruction words, region high gives data words
module bootRom (
    input  logic                          region,
    input  logic [bootPkg::addrWidth-1:0] addr,
    output logic [bootPkg::wordWidth-1:0] data
);
    import bootPkg::*;

    logic [wordWidth-1:0] instWord;
    logic [wordWidth-1:0] dataWord;

    always_comb begin
        instWord = instImage(addr);
        dataWord = dataImage(addr);
    end

    assign data = region ? dataWord : instWord;

endmodule

// ==== source/resetController.sv ====
`timescale 1ns/1ns

module resetController (
    input  logic       clk,
    input  logic       rstN,
    input  logic       softwareReset,
    input  logic [3:0] resetVector,
    input  logic       flashDone,
    output logic       instFlashReq,
    output logic       dataFlashReq,
    output logic       resetResponse,
    output logic       resetTrigger,
    output logic       cpuLockout,
    output logic       localResetBlock
);
    import bootPkg::*;

    resetState state;
    resetKind  kind;     // Kind being served
    resetKind  newKind;
    logic      kindValid;
    logic      ioStep;   // Second lockout cycle of an IO reset

    // Priority decode: Full > Inst > IO > Data
    always_comb begin
        kindValid = 1'b1;
        newKind   = kindFull;
        if (resetVector[vecFull]) begin
            newKind = kindFull;
        end else if (resetVector[vecInst]) begin
            newKind = kindInst;
        end else if (resetVector[vecIo]) begin
            newKind = kindIo;
        end else if (resetVector[vecData]) begin
            newKind = kindData;
        end else begin
            kindValid = 1'b0; // Empty vector, nothing to do
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state           <= idle;
            kind            <= kindFull;
            ioStep          <= 1'b0;
            instFlashReq    <= 1'b0;
            dataFlashReq    <= 1'b0;
            resetResponse   <= 1'b0;
            resetTrigger    <= 1'b0;
            cpuLockout      <= 1'b0;
            localResetBlock <= 1'b0;
        end else begin
            instFlashReq  <= 1'b0; // Strobes last one cycle
            dataFlashReq  <= 1'b0;
            resetResponse <= 1'b0;
            resetTrigger  <= 1'b0;
            case (state)
                idle: begin
                    // Strobes arriving outside idle are dropped
                    if (softwareReset && kindValid) begin
                        kind   <= newKind;
                        ioStep <= 1'b0;
                        case (newKind)
                            kindFull: begin
                                resetTrigger <= 1'b1;
                                state        <= submitReset;
                            end
                            kindIo: begin
                                resetTrigger    <= 1'b1;
                                cpuLockout      <= 1'b1;
                                localResetBlock <= 1'b1;
                                state           <= submitReset;
                            end
                            kindInst: begin
                                instFlashReq    <= 1'b1;
                                localResetBlock <= 1'b1; // Held over the whole reflash
                                state           <= flashInst;
                            end
                            default: begin
                                dataFlashReq <= 1'b1;
                                state        <= flashData;
                            end
                        endcase
                    end
                end
                flashInst: begin
                    if (flashDone) begin
                        localResetBlock <= 1'b0; // No reply for this kind
                        state           <= idle;
                    end
                end
                flashData: begin
                    if (flashDone) begin
                        resetResponse <= 1'b1;
                        state         <= idle;
                    end
                end
                submitReset: begin
                    if (kind == kindIo && !ioStep) begin
                        ioStep <= 1'b1; // Keep lockout one more cycle
                    end else begin
                        cpuLockout      <= 1'b0;
                        localResetBlock <= 1'b0;
                        resetResponse   <= 1'b1;
                        state           <= idle;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

endmodule

// ==== source/memoryFlasher.sv ====
`timescale 1ns/1ns

module memoryFlasher #(
    parameter int memMapStart = 384,
    parameter int memMapEnd   = 511
) (
    input  logic                          clk,
    input  logic                          rstN,
    input  logic                          flashInit,
    input  logic                          localResetBlock,
    input  logic                          instFlashReq,
    input  logic                          dataFlashReq,
    output logic                          flashBusy,
    output logic                          flashDone,
    output logic                          flashWe,
    output logic                          flashSel,
    output logic [bootPkg::addrWidth-1:0] flashAddr,
    output logic [bootPkg::wordWidth-1:0] flashWData,
    output logic                          romRegion,
    output logic [bootPkg::addrWidth-1:0] romAddr,
    input  logic [bootPkg::wordWidth-1:0] romData,
    output logic                          systemEnable
);
    import bootPkg::*;

    // First address after the I/O window, one bit wider so 1024 can mean done
    localparam logic [addrWidth:0] skipTarget = (addrWidth + 1)'(memMapEnd + 1);

    logic                 busy;
    logic                 phase;      // 0 instruction RAM, 1 data RAM
    logic                 bothPhases; // Power-up copy runs both images
    logic                 done;
    logic                 poweredUp;
    logic [addrWidth-1:0] addr;
    logic                 powerStart;
    logic                 skipNow;
    logic [addrWidth:0]   nextAddr;
    logic                 lastStep;

    assign powerStart = flashInit && !localResetBlock;

    // At the window start the data copy jumps past the window without writing
    assign skipNow  = phase && (addr == addrWidth'(memMapStart));
    assign nextAddr = skipNow ? skipTarget : {1'b0, addr} + 1'b1;
    assign lastStep = nextAddr[addrWidth];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            busy       <= 1'b0;
            phase      <= 1'b0;
            bothPhases <= 1'b0;
            done       <= 1'b0;
            poweredUp  <= 1'b0;
            addr       <= '0;
        end else begin
            done <= 1'b0;
            if (powerStart) begin
                busy       <= 1'b1;
                phase      <= 1'b0;
                bothPhases <= 1'b1;
                addr       <= '0;
            end else if (instFlashReq) begin
                busy       <= 1'b1;
                phase      <= 1'b0;
                bothPhases <= 1'b0;
                addr       <= '0;
            end else if (dataFlashReq) begin
                busy       <= 1'b1;
                phase      <= 1'b1;
                bothPhases <= 1'b0;
                addr       <= '0;
            end else if (busy) begin
                addr <= nextAddr[addrWidth-1:0];
                if (lastStep) begin
                    if (bothPhases && !phase) begin
                        phase <= 1'b1; // Data copy follows with no gap
                    end else begin
                        busy <= 1'b0;
                        done <= 1'b1;
                    end
                end
            end
            if (done && bothPhases) begin
                poweredUp <= 1'b1; // Sticky until rstN
            end
        end
    end

    assign flashBusy    = busy;
    assign flashDone    = done;
    assign flashWe      = busy && !skipNow;
    assign flashSel     = phase;
    assign flashAddr    = addr;
    assign flashWData   = romData;
    assign romRegion    = phase;
    assign romAddr      = addr;
    assign systemEnable = poweredUp;

endmodule

// ==== source/memArbiter.sv ====
`timescale 1ns/1ns

module memArbiter (
    input  logic                          clk,
    input  logic                          rstN,
    input  logic                          flashBusy,
    input  logic                          flashWe,
    input  logic                          flashSel,
    input  logic [bootPkg::addrWidth-1:0] flashAddr,
    input  logic [bootPkg::wordWidth-1:0] flashWData,
    input  logic                          hostEn,
    input  logic                          hostWe,
    input  logic                          hostSel,
    input  logic [bootPkg::addrWidth-1:0] hostAddr,
    input  logic [bootPkg::wordWidth-1:0] hostWData,
    output logic                          hostGrant,
    output logic [bootPkg::wordWidth-1:0] hostRData,
    output logic                          memWe,
    output logic                          memRe,
    output logic                          memSel,
    output logic [bootPkg::addrWidth-1:0] memAddr,
    output logic [bootPkg::wordWidth-1:0] memWData,
    input  logic [bootPkg::wordWidth-1:0] memRData
);
    import bootPkg::*;

    logic readPending; // Granted host read last cycle

    assign hostGrant = !flashBusy; // Flasher always wins

    assign memWe    = flashBusy ? flashWe : (hostEn && hostWe);
    assign memRe    = hostGrant && hostEn && !hostWe;
    assign memSel   = flashBusy ? flashSel : hostSel;
    assign memAddr  = flashBusy ? flashAddr : hostAddr;
    assign memWData = flashBusy ? flashWData : hostWData;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            readPending <= 1'b0;
        end else begin
            readPending <= memRe;
        end
    end

    assign hostRData = readPending ? memRData : {wordWidth{1'b0}};

endmodule

// ==== source/bootMemory.sv ====
`timescale 1ns/1ns

// Instruction RAM and data RAM sharing a single access port
module bootMemory (
    input  logic                          clk,
    input  logic                          memWe,
    input  logic                          memRe,
    input  logic                          memSel, // 0 instruction, 1 data
    input  logic [bootPkg::addrWidth-1:0] memAddr,
    input  logic [bootPkg::wordWidth-1:0] memWData,
    output logic [bootPkg::wordWidth-1:0] memRData
);
    import bootPkg::*;

    logic [wordWidth-1:0] instRam [memDepth];
    logic [wordWidth-1:0] dataRam [memDepth];

    always_ff @(posedge clk) begin
        if (memWe) begin
            if (memSel) begin
                dataRam[memAddr] <= memWData;
            end else begin
                instRam[memAddr] <= memWData;
            end
        end
    end

    // Registered read, data valid the cycle after memRe
    always_ff @(posedge clk) begin
        if (memRe) begin
            memRData <= memSel ? dataRam[memAddr] : instRam[memAddr];
        end
    end

endmodule

// ==== source/bootSubsystem.sv ====
`timescale 1ns/1ns

module bootSubsystem #(
    parameter int memMapStart = 384, // I/O window kept by the data copy
    parameter int memMapEnd   = 511
) (
    input  logic                          clk,
    input  logic                          rstN,
    input  logic                          flashInit,
    input  logic                          softwareReset,
    input  logic [3:0]                    resetVector,
    output logic                          resetResponse,
    output logic                          resetTrigger,
    output logic                          cpuLockout,
    output logic                          systemEnable,
    input  logic                          hostEn,
    input  logic                          hostWe,
    input  logic                          hostSel,
    input  logic [bootPkg::addrWidth-1:0] hostAddr,
    input  logic [bootPkg::wordWidth-1:0] hostWData,
    output logic                          hostGrant,
    output logic [bootPkg::wordWidth-1:0] hostRData
);
    import bootPkg::*;

    logic                 instFlashReq;
    logic                 dataFlashReq;
    logic                 flashDone;
    logic                 localResetBlock;
    logic                 flashBusy;
    logic                 flashWe;
    logic                 flashSel;
    logic [addrWidth-1:0] flashAddr;
    logic [wordWidth-1:0] flashWData;
    logic                 romRegion;
    logic [addrWidth-1:0] romAddr;
    logic [wordWidth-1:0] romData;
    logic                 memWe;
    logic                 memRe;
    logic                 memSel;
    logic [addrWidth-1:0] memAddr;
    logic [wordWidth-1:0] memWData;
    logic [wordWidth-1:0] memRData;

    resetController resetController_i (
        .clk            (clk),
        .rstN           (rstN),
        .softwareReset  (softwareReset),
        .resetVector    (resetVector),
        .flashDone      (flashDone),
        .instFlashReq   (instFlashReq),
        .dataFlashReq   (dataFlashReq),
        .resetResponse  (resetResponse),
        .resetTrigger   (resetTrigger),
        .cpuLockout     (cpuLockout),
        .localResetBlock(localResetBlock)
    );

    memoryFlasher #(
        .memMapStart(memMapStart),
        .memMapEnd  (memMapEnd)
    ) memoryFlasher_i (
        .clk            (clk),
        .rstN           (rstN),
        .flashInit      (flashInit),
        .localResetBlock(localResetBlock),
        .instFlashReq   (instFlashReq),
        .dataFlashReq   (dataFlashReq),
        .flashBusy      (flashBusy),
        .flashDone      (flashDone),
        .flashWe        (flashWe),
        .flashSel       (flashSel),
        .flashAddr      (flashAddr),
        .flashWData     (flashWData),
        .romRegion      (romRegion),
        .romAddr        (romAddr),
        .romData        (romData),
        .systemEnable   (systemEnable)
    );

    bootRom bootRom_i (
        .region(romRegion),
        .addr  (romAddr),
        .data  (romData)
    );

    memArbiter memArbiter_i (
        .clk       (clk),
        .rstN      (rstN),
        .flashBusy (flashBusy),
        .flashWe   (flashWe),
        .flashSel  (flashSel),
        .flashAddr (flashAddr),
        .flashWData(flashWData),
        .hostEn    (hostEn),
        .hostWe    (hostWe),
        .hostSel   (hostSel),
        .hostAddr  (hostAddr),
        .hostWData (hostWData),
        .hostGrant (hostGrant),
        .hostRData (hostRData),
        .memWe     (memWe),
        .memRe     (memRe),
        .memSel    (memSel),
        .memAddr   (memAddr),
        .memWData  (memWData),
        .memRData  (memRData)
    );

    bootMemory bootMemory_i (
        .clk     (clk),
        .memWe   (memWe),
        .memRe   (memRe),
        .memSel  (memSel),
        .memAddr (memAddr),
        .memWData(memWData),
        .memRData(memRData)
    );

endmodule

// ==== tests/bootSubsystemTb.sv ====
`timescale 1ns/1ns

module bootSubsystemTb;

    localparam int winStart     = 384; // I/O window kept by the data copy
    localparam int winEnd       = 511;
    localparam int grantTimeout = 4000;
    localparam int copyTimeout  = 5000;
    localparam int resetTimeout = 3000;

    logic        clk;
    logic        rstN;
    logic        flashInit;
    logic        softwareReset;
    logic [3:0]  resetVector;
    logic        resetResponse;
    logic        resetTrigger;
    logic        cpuLockout;
    logic        systemEnable;
    logic        hostEn;
    logic        hostWe;
    logic        hostSel;
    logic [9:0]  hostAddr;
    logic [15:0] hostWData;
    logic        hostGrant;
    logic [15:0] hostRData;

    integer seed;
    int     errors;
    int     checks;
    int     tests;
    bit     timedOut;

    bootSubsystem #(
        .memMapStart(winStart),
        .memMapEnd  (winEnd)
    ) bootSubsystem_i (
        .clk          (clk),
        .rstN         (rstN),
        .flashInit    (flashInit),
        .softwareReset(softwareReset),
        .resetVector  (resetVector),
        .resetResponse(resetResponse),
        .resetTrigger (resetTrigger),
        .cpuLockout   (cpuLockout),
        .systemEnable (systemEnable),
        .hostEn       (hostEn),
        .hostWe       (hostWe),
        .hostSel      (hostSel),
        .hostAddr     (hostAddr),
        .hostWData    (hostWData),
        .hostGrant    (hostGrant),
        .hostRData    (hostRData)
    );

    always #50 clk = ~clk;

    // Instruction image 3a + 1000h and data image as the inverted address
    function automatic logic [15:0] expectedInst(input logic [9:0] a);
        logic [15:0] w;
        w = {6'b0, a};
        return w * 16'd3 + 16'h1000;
    endfunction

    function automatic logic [15:0] expectedData(input logic [9:0] a);
        return ~{6'b0, a};
    endfunction

    task automatic reportMismatch(input string name, input logic [15:0] exp,
                                  input logic [15:0] act);
        $display("ERROR t=%0t %s expected %h actual %h", $time, name, exp, act);
        errors++;
    endtask

    task automatic reportTimeout(input string what);
        $display("ERROR t=%0t timed out waiting for %s", $time, what);
        errors++;
        timedOut = 1'b1;
    endtask

    task automatic waitForGrant();
        int cycles;
        cycles = 0;
        while (!hostGrant && cycles < grantTimeout) begin
            @(negedge clk);
            cycles++;
        end
        if (!hostGrant) reportTimeout("hostGrant");
    endtask

    task automatic hostWrite(input logic sel, input logic [9:0] addr, input logic [15:0] data);
        waitForGrant();
        if (timedOut) return;
        hostEn    = 1'b1;
        hostWe    = 1'b1;
        hostSel   = sel;
        hostAddr  = addr;
        hostWData = data;
        @(negedge clk);
        hostEn = 1'b0;
        hostWe = 1'b0;
    endtask

    // Read data shows up one cycle after the granted request
    task automatic hostReadCheck(input logic sel, input logic [9:0] addr,
                                 input logic [15:0] exp);
        waitForGrant();
        if (timedOut) return;
        hostEn   = 1'b1;
        hostWe   = 1'b0;
        hostSel  = sel;
        hostAddr = addr;
        @(negedge clk);
        hostEn = 1'b0;
        checks++;
        if (hostRData !== exp) begin
            reportMismatch($sformatf("hostRData sel %0d addr %0d", sel, addr), exp, hostRData);
        end
    endtask

    task automatic spotCheck(input logic sel, input int count);
        logic [9:0] addr;
        int         tries;
        for (int i = 0; i < count; i++) begin
            addr  = 10'($random(seed));
            tries = 0;
            while (sel && int'(addr) >= winStart && int'(addr) <= winEnd && tries < 16) begin
                addr = 10'($random(seed)); // Window words hold host data
                tries++;
            end
            if (sel && int'(addr) >= winStart && int'(addr) <= winEnd) addr = '0;
            hostReadCheck(sel, addr, sel ? expectedData(addr) : expectedInst(addr));
        end
    endtask

    task automatic powerUp();
        int busyCycles;
        int cycles;
        busyCycles = 0;
        cycles     = 0;
        checks++;
        if (systemEnable) begin
            $display("ERROR t=%0t systemEnable was already high before the copy", $time);
            errors++;
        end
        flashInit = 1'b1;
        @(negedge clk);
        flashInit = 1'b0;
        while (!hostGrant && busyCycles < copyTimeout) begin
            busyCycles++;
            @(negedge clk);
        end
        if (!hostGrant) begin
            reportTimeout("end of the power-up copy");
            return;
        end
        checks++;
        // Both images minus the skipped window
        if (busyCycles <= 1024 || busyCycles >= 2048) begin
            $display("ERROR t=%0t host was locked out for %0d cycles, not a two-image copy",
                     $time, busyCycles);
            errors++;
        end
        while (!systemEnable && cycles < 8) begin
            @(negedge clk);
            cycles++;
        end
        if (!systemEnable) reportTimeout("systemEnable");
    endtask

    // Expected counts as hex digits for trigger pulses, lockout cycles and response pulses
    task automatic softReset(input logic [3:0] vec, input logic [15:0] expCounts);
        int trig;
        int lock;
        int resp;
        int expTrig;
        int expLock;
        int expResp;
        int trigAt;
        int respAt;
        int cycles;
        int settle;
        int gap;
        bit sawCopy;
        trig    = 0;
        lock    = 0;
        resp    = 0;
        expTrig = int'(expCounts[11:8]);
        expLock = int'(expCounts[7:4]);
        expResp = int'(expCounts[3:0]);
        trigAt  = -1;
        respAt  = -1;
        cycles  = 0;
        settle  = 0;
        sawCopy = 1'b0;
        resetVector   = vec;
        softwareReset = 1'b1;
        @(negedge clk);
        softwareReset = 1'b0;
        while (settle < 8 && cycles < resetTimeout) begin
            if (resetTrigger) begin
                trig++;
                trigAt = cycles;
            end
            if (cpuLockout) lock++;
            if (resetResponse) begin
                resp++;
                respAt = cycles;
            end
            if (!hostGrant) sawCopy = 1'b1;
            if (hostGrant && (resp > 0 || sawCopy)) settle++; // Watch for stray pulses
            cycles++;
            @(negedge clk);
        end
        if (settle < 8) begin
            reportTimeout($sformatf("software reset %b to finish", vec));
            return;
        end
        checks += 3;
        if (trig != expTrig) reportMismatch("resetTrigger pulses", 16'(expTrig), 16'(trig));
        if (lock != expLock) reportMismatch("cpuLockout cycles", 16'(expLock), 16'(lock));
        if (resp != expResp) reportMismatch("resetResponse pulses", 16'(expResp), 16'(resp));
        // Trigger kinds leave both RAMs alone, so the host keeps its grant
        checks++;
        if (expTrig > 0 && sawCopy) begin
            $display("ERROR t=%0t software reset %b started a memory copy", $time, vec);
            errors++;
        end
        if (trig == 1 && resp == 1) begin
            gap = (expLock > 0) ? expLock : 1;
            checks++;
            if (trigAt != 0 || respAt != trigAt + gap) begin
                $display("ERROR t=%0t trigger at cycle %0d and response at %0d, %s %0d",
                         $time, trigAt, respAt, "expected 0 and", gap);
                errors++;
            end
        end
    endtask

    initial begin
        int          fd;
        int          n;
        int          errAtStart;
        string       line;
        string       op;
        logic [3:0]  fSel;
        logic [11:0] fAddr;
        logic [15:0] fData;
        seed          = 32'h5fcc1de3;
        errors        = 0;
        checks        = 0;
        tests         = 0;
        timedOut      = 1'b0;
        errAtStart    = 0;
        clk           = 1'b0;
        rstN          = 1'b0;
        flashInit     = 1'b0;
        softwareReset = 1'b0;
        resetVector   = '0;
        hostEn        = 1'b0;
        hostWe        = 1'b0;
        hostSel       = 1'b0;
        hostAddr      = '0;
        hostWData     = '0;
        repeat (2) @(negedge clk);
        rstN = 1'b1;
        @(negedge clk);

        fd = $fopen("tests/bootVectors.txt", "r");
        if (fd == 0) begin
            $display("ERROR could not open tests/bootVectors.txt");
            errors++;
        end else begin
            while (!timedOut && $fgets(line, fd) != 0) begin
                if (line.len() < 2 || line[0] == "#") continue;
                n = $sscanf(line, "%s %h %h %h", op, fSel, fAddr, fData);
                if (n != 4) begin
                    $display("ERROR malformed vector line: %s", line);
                    errors++;
                    continue;
                end
                if (op == "init") powerUp();
                else if (op == "write") hostWrite(fSel[0], fAddr[9:0], fData);
                else if (op == "read") hostReadCheck(fSel[0], fAddr[9:0], fData);
                else if (op == "spot") spotCheck(fSel[0], int'(fAddr));
                else if (op == "swreset") softReset(fAddr[3:0], fData);
                else if (op == "waitidle") waitForGrant();
                else if (op == "done") begin
                    tests++;
                    if (errors == errAtStart) $display("test %0d passed", fAddr);
                    else $display("test %0d failed with %0d errors", fAddr, errors - errAtStart);
                    errAtStart = errors;
                end else begin
                    $display("ERROR unknown opcode %s in vector file", op);
                    errors++;
                end
            end
            $fclose(fd);
        end

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0 && !timedOut) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== tests/bootVectors.txt ====
# opcode select address-or-vector data-or-expected, numbers in hex
# swreset expected digits: trigger pulses, lockout cycles, response pulses
write 1 180 1234
write 1 190 beef
write 1 1ff 5a5a
init 0 000 0000
read 0 000 1000
read 0 200 1600
read 0 3ff 1bfd
read 1 000 ffff
read 1 3ff fc00
spot 0 008 0000
spot 1 008 0000
done 0 001 0000
read 1 180 1234
read 1 190 beef
read 1 1ff 5a5a
read 1 17f fe80
read 1 200 fdff
done 0 002 0000
write 1 064 0001
write 1 190 2222
swreset 0 001 0001
waitidle 0 000 0000
read 1 064 ff9b
read 1 190 2222
done 0 003 0000
write 0 005 dead
write 0 3ff 0000
swreset 0 004 0000
waitidle 0 000 0000
read 0 005 100f
read 0 3ff 1bfd
done 0 004 0000
swreset 0 002 0121
swreset 0 00f 0101
read 1 190 2222
read 1 064 ff9b
read 0 005 100f
done 0 005 0000

// ==== sources.f ====
source/bootPkg.sv
source/bootRom.sv
source/resetController.sv
source/memoryFlasher.sv
source/memArbiter.sv
source/bootMemory.sv
source/bootSubsystem.sv
tests/bootSubsystemTb.sv

// ==== runSim.sh ====
#!/bin/bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module bootSubsystemTb -f sources.f -o bootSim || exit 1
simOut=$(./obj_dir/bootSim)
echo "$simOut"
echo "$simOut" | grep -qx "PASS: all tests" && exit 0 || exit 1
